//--- verilog.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/strand_queue.sv
hdl/round_robin_arbiter.sv
hdl/strand_select_stage.sv
hdl/execute_pipelines.sv
hdl/issue_core.sv
bench/issue_core_assert.sv
bench/issue_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the issue core testbench with Verilator and run it.
# Exits with zero only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module issue_core_tb -f verilog.f -o issue_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issue_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1

//--- bench/issue_core_tb.sv
/*
 * Testbench for the issue core. Acts as fetch for every strand, keeps a
 * per-strand model of accepted words and checks each writeback against it.
 */

`timescale 1ns/1ns

`include "issue_params.svh"

module issue_core_tb;

	// Words per strand in each phase
	localparam int RANDOM_WORDS = 26;
	localparam int FAIR_WORDS = 8;
	localparam int SOLO_WORDS = 2;
	localparam int WORDS_PER_STRAND = RANDOM_WORDS + `QUEUE_DEPTH + FAIR_WORDS + SOLO_WORDS;
	// About 20 cycles per word at worst, plus margin
	localparam int MAX_CYCLES = 25 * `STRANDS * WORDS_PER_STRAND;

	typedef enum {PHASE_FREE, PHASE_HOLD, PHASE_FAIR, PHASE_SOLO} phase_t;

	logic clk;
	logic reset;
	issue_pkg::strand_mask_t strand_enable;
	issue_pkg::strand_mask_t fetch_valid;
	logic [`STRANDS * 32 - 1:0] fetch_pc;
	logic [`STRANDS * 32 - 1:0] fetch_instruction;
	issue_pkg::strand_mask_t fetch_long_latency;
	issue_pkg::strand_mask_t fetch_ready;
	logic wb_valid;
	issue_pkg::strand_idx_t wb_strand;
	issue_pkg::word_t wb_pc;
	issue_pkg::word_t wb_instruction;
	logic wb_long_latency;
	logic issue_event;

	// Accepted words not yet written back, per strand
	issue_pkg::queue_entry_t expected[`STRANDS][$];
	// Cycle of each grant while a single strand runs
	int issue_cycles[$];
	int fetch_seq[`STRANDS];
	bit taken[`STRANDS];
	int seed = 67;
	int errors = 0;
	int accepted = 0;
	int writebacks = 0;
	int cycle_count = 0;
	int last_fair_strand = -1;
	phase_t phase = PHASE_FREE;

	issue_core issue_core_i(
		.clk(clk),
		.reset(reset),
		.strand_enable(strand_enable),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_instruction(fetch_instruction),
		.fetch_long_latency(fetch_long_latency),
		.fetch_ready(fetch_ready),
		.wb_valid(wb_valid),
		.wb_strand(wb_strand),
		.wb_pc(wb_pc),
		.wb_instruction(wb_instruction),
		.wb_long_latency(wb_long_latency),
		.issue_event(issue_event));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Strand in the top byte, sequence number lower down
	function automatic issue_pkg::word_t word_pc(input int strand, input int seq);
		return {8'(strand), 8'h00, 14'(seq), 2'b00};
	endfunction

	function automatic issue_pkg::word_t word_instruction(input int strand, input int seq);
		return {8'hc0 | 8'(strand), 8'h5a, 16'(seq)};
	endfunction

	// Oldest accepted word of the strand is the next one to write back
	function automatic issue_pkg::queue_entry_t expected_writeback(input int strand);
		return expected[strand][0];
	endfunction

	task automatic check_writeback();
		issue_pkg::queue_entry_t want;
		int strand;

		strand = int'(wb_strand);
		writebacks++;
		assert (expected[strand].size() != 0)
		else
		begin
			errors++;
			$display("Error: %0t ns: strand %0d wrote back with no word pending", $time, strand);
		end
		if (expected[strand].size() != 0)
		begin
			want = expected_writeback(strand);
			void'(expected[strand].pop_front());
			assert (wb_pc == want.pc && wb_instruction == want.instruction
				&& wb_long_latency == want.long_latency)
			else
			begin
				errors++;
				$display("Error: %0t ns: strand %0d got %h %h %b, expected %h %h %b", $time,
					strand, wb_pc, wb_instruction, wb_long_latency,
					want.pc, want.instruction, want.long_latency);
			end
		end
		assert (phase != PHASE_HOLD)
		else
		begin
			errors++;
			$display("Error: %0t ns: strand %0d wrote back while disabled", $time, strand);
		end
		if (phase == PHASE_FAIR)
		begin
			assert (last_fair_strand < 0 || strand == (last_fair_strand + 1) % `STRANDS)
			else
			begin
				errors++;
				$display("Error: %0t ns: strand %0d followed strand %0d out of turn", $time,
					strand, last_fair_strand);
			end
			last_fair_strand = strand;
		end
		if (phase == PHASE_SOLO)
		begin
			assert (issue_cycles.size() != 0 && cycle_count - issue_cycles[0] == 2)
			else
			begin
				errors++;
				$display("Error: %0t ns: short writeback not two cycles after its issue", $time);
			end
			if (issue_cycles.size() != 0)
				void'(issue_cycles.pop_front());
		end
	endtask

	// Fetch transfers into the model, then writeback compare
	always @(posedge clk)
	begin
		for (int s = 0; s < `STRANDS; s++)
		begin
			if (fetch_valid[s] && fetch_ready[s])
			begin
				expected[s].push_back('{pc: fetch_pc[s * 32 +: 32],
					instruction: fetch_instruction[s * 32 +: 32],
					long_latency: fetch_long_latency[s]});
				fetch_seq[s]++;
				taken[s] = 1'b1;
				accepted++;
			end
		end
		if (issue_event && phase == PHASE_SOLO)
			issue_cycles.push_back(cycle_count);
		if (wb_valid)
			check_writeback();
		cycle_count++;
	end

	// Held strands: ready drops exactly when the queue holds QUEUE_DEPTH words
	always @(negedge clk)
	begin
		if (phase == PHASE_HOLD)
		begin
			for (int s = 0; s < `STRANDS; s++)
			begin
				assert (fetch_ready[s] == (expected[s].size() < `QUEUE_DEPTH))
				else
				begin
					errors++;
					$display("Error: %0t ns: strand %0d fetch_ready %b with %0d words queued",
						$time, s, fetch_ready[s], expected[s].size());
				end
			end
		end
	end

	// Fetch count words on each selected strand, each held until it transfers
	task automatic send_words(input issue_pkg::strand_mask_t strands, input int count,
		input bit random_traffic);
		int left[`STRANDS];
		bit busy;

		for (int s = 0; s < `STRANDS; s++)
			left[s] = strands[s] ? count : 0;
		busy = 1'b1;
		while (busy)
		begin
			@(negedge clk);
			busy = 1'b0;
			if (random_traffic)
				strand_enable = issue_pkg::strand_mask_t'($random(seed));
			for (int s = 0; s < `STRANDS; s++)
			begin
				if (taken[s])
				begin
					taken[s] = 1'b0;
					fetch_valid[s] = 1'b0;
					left[s]--;
				end
				if (left[s] != 0)
					busy = 1'b1;
				if (left[s] != 0 && !fetch_valid[s]
					&& (!random_traffic || ($random(seed) & 1) == 0))
				begin
					fetch_valid[s] = 1'b1;
					fetch_pc[s * 32 +: 32] = word_pc(s, fetch_seq[s]);
					fetch_instruction[s * 32 +: 32] = word_instruction(s, fetch_seq[s]);
					fetch_long_latency[s] = random_traffic ? 1'($random(seed)) : 1'b0;
				end
			end
		end
	endtask

	// Until every accepted word has written back
	task automatic wait_drain();
		int pending;

		do
		begin
			@(negedge clk);
			pending = 0;
			for (int s = 0; s < `STRANDS; s++)
				pending += expected[s].size();
		end
		while (pending != 0);
	endtask

	initial
	begin
		reset = 1'b1;
		strand_enable = '1;
		fetch_valid = '0;
		fetch_pc = '0;
		fetch_instruction = '0;
		fetch_long_latency = '0;
		for (int s = 0; s < `STRANDS; s++)
		begin
			fetch_seq[s] = 0;
			taken[s] = 1'b0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Mixed short and long words, strands switched on and off
		send_words('1, RANDOM_WORDS, 1'b1);
		strand_enable = '1;
		wait_drain();

		// Every strand held, queues fill until fetch stalls
		strand_enable = '0;
		phase = PHASE_HOLD;
		send_words('1, `QUEUE_DEPTH, 1'b0);
		repeat (4) @(negedge clk);
		phase = PHASE_FREE;
		strand_enable = '1;
		wait_drain();

		// All strands busy with short words
		phase = PHASE_FAIR;
		send_words('1, FAIR_WORDS, 1'b0);
		wait_drain();

		// One strand at a time for issue to writeback timing
		phase = PHASE_SOLO;
		for (int s = 0; s < `STRANDS; s++)
		begin
			send_words(issue_pkg::strand_mask_t'(1) << s, SOLO_WORDS, 1'b0);
			wait_drain();
		end
		phase = PHASE_FREE;
		repeat (6) @(negedge clk);

		assert (accepted == `STRANDS * WORDS_PER_STRAND && writebacks == accepted)
		else
		begin
			errors++;
			$display("Error: %0t ns: %0d words accepted, %0d written back", $time,
				accepted, writebacks);
		end
		$display("Summary: %0d errors, %0d words accepted, %0d written back",
			errors, accepted, writebacks);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		while (cycle_count < MAX_CYCLES)
			@(negedge clk);
		$display("Timeout: the run did not finish within %0d cycles, %0d errors so far",
			MAX_CYCLES, errors);
		$display("FAIL: see errors above");
		$finish;
	end
endmodule

//--- bench/issue_core_assert.sv
/*
 * Concurrent checks bound into every strand queue and into the issue core top.
 * Ports that one target lacks are tied off where the checker is bound.
 */

`timescale 1ns/1ns

module issue_core_assert(
	input clk,
	input reset,

	// Queue side
	input push,
	input pop,
	input full,
	input empty,

	// Writeback side
	input wb_valid,
	input wb_long_latency,
	input issue_pkg::strand_mask_t resume_strand);

	// Fetch never writes into a full queue
	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		push |-> !full)
		else $error("push into a full strand queue");

	// A grant only pops a queue that holds a word
	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty)
		else $error("pop from an empty strand queue");

	// Long writeback wakes exactly one strand, short wakes none
	resume_with_long: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> ($onehot(resume_strand) == wb_long_latency))
		else $error("resume pulse does not match the long flag at writeback");

	// No wake-up without a long writeback
	resume_only_on_writeback: assert property (@(posedge clk) disable iff (reset)
		(resume_strand != '0) |-> (wb_valid && wb_long_latency))
		else $error("resume pulse without a long writeback");
endmodule

bind strand_queue issue_core_assert queue_assert_i(
	.clk(clk),
	.reset(reset),
	.push(push),
	.pop(out_ready),
	.full(count == COUNT_WIDTH'(DEPTH)),
	.empty(count == '0),
	.wb_valid(1'b0),
	.wb_long_latency(1'b0),
	.resume_strand('0));

bind issue_core issue_core_assert core_assert_i(
	.clk(clk),
	.reset(reset),
	.push(1'b0),
	.pop(1'b0),
	.full(1'b0),
	.empty(1'b0),
	.wb_valid(wb_valid),
	.wb_long_latency(wb_long_latency),
	.resume_strand(resume_strand));

//--- hdl/issue_core.sv
/*
 * Top level of the issue side: per-strand queues, strand select and execute.
 * Fetch drives one valid/ready channel per strand; results leave on one port.
 */

`timescale 1ns/1ns

`include "issue_params.svh"

module issue_core(
	input clk,
	input reset,
	input issue_pkg::strand_mask_t strand_enable,

	// Fetch, strand 0 in the lowest slice
	input issue_pkg::strand_mask_t fetch_valid,
	input [`STRANDS * 32 - 1:0] fetch_pc,
	input [`STRANDS * 32 - 1:0] fetch_instruction,
	input issue_pkg::strand_mask_t fetch_long_latency,
	output issue_pkg::strand_mask_t fetch_ready,

	// Writeback
	output logic wb_valid,
	output issue_pkg::strand_idx_t wb_strand,
	output issue_pkg::word_t wb_pc,
	output issue_pkg::word_t wb_instruction,
	output logic wb_long_latency,

	output logic issue_event);

	// Queue heads
	issue_pkg::strand_mask_t q_valid;
	logic [`STRANDS * 32 - 1:0] q_pc;
	logic [`STRANDS * 32 - 1:0] q_instruction;
	issue_pkg::strand_mask_t q_long_latency;
	issue_pkg::strand_mask_t issue_oh;

	// Select stage to pipelines
	logic ss_valid;
	issue_pkg::strand_idx_t ss_strand;
	issue_pkg::word_t ss_pc;
	issue_pkg::word_t ss_instruction;
	logic ss_long_latency;
	issue_pkg::strand_mask_t resume_strand;

	genvar strand_id;

	generate
		for (strand_id = 0; strand_id < `STRANDS; strand_id++)
		begin : queue
			strand_queue #(.DEPTH(`QUEUE_DEPTH)) strand_queue_i(
				.clk(clk),
				.reset(reset),
				.in_valid(fetch_valid[strand_id]),
				.in_pc(fetch_pc[strand_id * 32 +: 32]),
				.in_instruction(fetch_instruction[strand_id * 32 +: 32]),
				.in_long_latency(fetch_long_latency[strand_id]),
				.in_ready(fetch_ready[strand_id]),
				.out_valid(q_valid[strand_id]),
				.out_pc(q_pc[strand_id * 32 +: 32]),
				.out_instruction(q_instruction[strand_id * 32 +: 32]),
				.out_long_latency(q_long_latency[strand_id]),
				// Grant pops the head
				.out_ready(issue_oh[strand_id]));
		end
	endgenerate

	strand_select_stage strand_select_stage_i(
		.clk(clk),
		.reset(reset),
		.strand_enable(strand_enable),
		.q_valid(q_valid),
		.q_pc(q_pc),
		.q_instruction(q_instruction),
		.q_long_latency(q_long_latency),
		.issue_oh(issue_oh),
		.resume_strand(resume_strand),
		.ss_valid(ss_valid),
		.ss_strand(ss_strand),
		.ss_pc(ss_pc),
		.ss_instruction(ss_instruction),
		.ss_long_latency(ss_long_latency),
		.issue_event(issue_event));

	execute_pipelines execute_pipelines_i(
		.clk(clk),
		.reset(reset),
		.ss_valid(ss_valid),
		.ss_strand(ss_strand),
		.ss_pc(ss_pc),
		.ss_instruction(ss_instruction),
		.ss_long_latency(ss_long_latency),
		.wb_valid(wb_valid),
		.wb_strand(wb_strand),
		.wb_pc(wb_pc),
		.wb_instruction(wb_instruction),
		.wb_long_latency(wb_long_latency),
		.resume_strand(resume_strand));
endmodule

//--- hdl/execute_pipelines.sv
/*
 * Single-stage and multi-stage execute pipelines feeding one writeback port.
 * Instructions pass through unchanged; a long one leaving raises its strand's resume.
 */

`timescale 1ns/1ns

`include "issue_params.svh"

module execute_pipelines(
	input clk,
	input reset,

	// From select stage
	input ss_valid,
	input issue_pkg::strand_idx_t ss_strand,
	input issue_pkg::word_t ss_pc,
	input issue_pkg::word_t ss_instruction,
	input ss_long_latency,

	// Writeback port
	output logic wb_valid,
	output issue_pkg::strand_idx_t wb_strand,
	output issue_pkg::word_t wb_pc,
	output issue_pkg::word_t wb_instruction,
	output logic wb_long_latency,

	// Back to select stage
	output issue_pkg::strand_mask_t resume_strand);

	localparam LAST = `LONG_STAGES - 1;

	issue_pkg::queue_entry_t ss_entry;

	// Short pipeline, one stage
	logic short_valid;
	issue_pkg::strand_idx_t short_strand;
	issue_pkg::queue_entry_t short_entry;

	// Long pipeline
	logic [`LONG_STAGES - 1:0] long_valid;
	issue_pkg::strand_idx_t long_strand[`LONG_STAGES];
	issue_pkg::queue_entry_t long_entry[`LONG_STAGES];

	logic long_done;
	issue_pkg::queue_entry_t wb_entry;

	assign ss_entry = '{pc: ss_pc, instruction: ss_instruction,
		long_latency: ss_long_latency};

	// Valid bits
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			short_valid <= 1'b0;
			long_valid <= '0;
		end
		else
		begin
			short_valid <= ss_valid && !ss_long_latency;
			long_valid <= {long_valid[LAST - 1:0], ss_valid && ss_long_latency};
		end
	end

	// Payload moves along with its valid bit
	always_ff @(posedge clk)
	begin
		short_strand <= ss_strand;
		short_entry <= ss_entry;
		long_strand[0] <= ss_strand;
		long_entry[0] <= ss_entry;
		for (int i = 1; i < `LONG_STAGES; i++)
		begin
			long_strand[i] <= long_strand[i - 1];
			long_entry[i] <= long_entry[i - 1];
		end
	end

	// Merge; select stage guarantees both ends are never valid together
	assign long_done = long_valid[LAST];
	assign wb_valid = long_done || short_valid;
	assign wb_entry = long_done ? long_entry[LAST] : short_entry;
	assign wb_strand = long_done ? long_strand[LAST] : short_strand;
	assign wb_pc = wb_entry.pc;
	assign wb_instruction = wb_entry.instruction;
	assign wb_long_latency = wb_entry.long_latency;

	// Wake the strand whose long instruction is leaving
	assign resume_strand = long_done
		? issue_pkg::strand_mask_t'(1) << long_strand[LAST]
		: issue_pkg::strand_mask_t'(0);
endmodule

//--- hdl/strand_select_stage.sv
/*
 * Strand select stage: picks one ready strand per cycle and registers its head
 * instruction for the execute pipelines. Holds back strands with a long
 * instruction in flight and avoids the short/long writeback collision.
 */

`timescale 1ns/1ns

`include "issue_params.svh"

module strand_select_stage(
	input clk,
	input reset,

	// Per-strand enable
	input issue_pkg::strand_mask_t strand_enable,

	// Queue heads, strand 0 in the lowest slice
	input issue_pkg::strand_mask_t q_valid,
	input [`STRANDS * 32 - 1:0] q_pc,
	input [`STRANDS * 32 - 1:0] q_instruction,
	input issue_pkg::strand_mask_t q_long_latency,
	output issue_pkg::strand_mask_t issue_oh,

	// Long instruction has written back
	input issue_pkg::strand_mask_t resume_strand,

	// To execute pipelines
	output logic ss_valid,
	output issue_pkg::strand_idx_t ss_strand,
	output issue_pkg::word_t ss_pc,
	output issue_pkg::word_t ss_instruction,
	output logic ss_long_latency,

	// Performance event
	output logic issue_event);

	localparam WORD_WIDTH = $bits(issue_pkg::word_t);

	// Strands waiting on a long instruction
	issue_pkg::strand_mask_t suspended;

	// Long grants one and two cycles back
	logic [1:0] long_issue_ff;

	issue_pkg::strand_mask_t short_head;
	issue_pkg::strand_mask_t execute_hazard;
	issue_pkg::strand_mask_t request;
	issue_pkg::strand_idx_t grant_idx;
	issue_pkg::word_t selected_pc;
	issue_pkg::word_t selected_instruction;
	logic selected_long_latency;
	logic grant_any;
	logic issue_long;

	// A short head granted now meets a long grant from two cycles ago at writeback
	assign short_head = q_valid & ~q_long_latency;
	assign execute_hazard = {`STRANDS{long_issue_ff[1]}} & short_head;

	// Eligible strands
	assign request = q_valid & strand_enable & ~suspended & ~execute_hazard;

	round_robin_arbiter #(.NUM_REQUESTERS(`STRANDS)) issue_arbiter(
		.clk(clk),
		.reset(reset),
		.request(request),
		.grant_oh(issue_oh),
		.grant_idx(grant_idx));

	assign grant_any = issue_oh != '0;
	assign issue_event = grant_any;

	// Granted strand's head
	assign selected_pc = q_pc[grant_idx * WORD_WIDTH +: WORD_WIDTH];
	assign selected_instruction = q_instruction[grant_idx * WORD_WIDTH +: WORD_WIDTH];
	assign selected_long_latency = q_long_latency[grant_idx];
	assign issue_long = grant_any && selected_long_latency;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			suspended <= '0;
			long_issue_ff <= '0;
			ss_valid <= 1'b0;
			ss_strand <= '0;
			ss_pc <= '0;
			ss_instruction <= `NOP;
			ss_long_latency <= 1'b0;
		end
		else
		begin
			long_issue_ff <= {long_issue_ff[0], issue_long};

			// Resume clears, a long grant sets
			suspended <= (suspended & ~resume_strand)
				| (issue_long ? issue_oh : issue_pkg::strand_mask_t'(0));

			if (grant_any)
			begin
				ss_valid <= 1'b1;
				ss_strand <= grant_idx;
				ss_pc <= selected_pc;
				ss_instruction <= selected_instruction;
				ss_long_latency <= selected_long_latency;
			end
			else
			begin
				// Nothing eligible, send a bubble
				ss_valid <= 1'b0;
				ss_strand <= '0;
				ss_pc <= '0;
				ss_instruction <= `NOP;
				ss_long_latency <= 1'b0;
			end
		end
	end
endmodule

//--- hdl/round_robin_arbiter.sv
/*
 * Rotating-priority arbiter, one-hot grant plus the granted index.
 * Priority starts just past the last grant and only moves when a grant is made.
 */

`timescale 1ns/1ns

module round_robin_arbiter
	#(parameter NUM_REQUESTERS = 4)
	(input clk,
	input reset,
	input [NUM_REQUESTERS - 1:0] request,
	output logic [NUM_REQUESTERS - 1:0] grant_oh,
	output logic [$clog2(NUM_REQUESTERS) - 1:0] grant_idx);

	localparam IDX_WIDTH = $clog2(NUM_REQUESTERS);

	// Position of the most recent grant
	logic [IDX_WIDTH - 1:0] last_grant;

	always_comb
	begin
		int candidate;

		candidate = 0;
		grant_oh = '0;
		grant_idx = '0;

		// Walk from furthest to nearest so the nearest requester wins
		for (int i = NUM_REQUESTERS; i > 0; i--)
		begin
			candidate = (int'(last_grant) + i) % NUM_REQUESTERS;
			if (request[candidate])
			begin
				grant_oh = '0;
				grant_oh[candidate] = 1'b1;
				grant_idx = IDX_WIDTH'(candidate);
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Requester 0 has priority first
			last_grant <= IDX_WIDTH'(NUM_REQUESTERS - 1);
		end
		else if (request != '0)
			last_grant <= grant_idx;
	end
endmodule

//--- hdl/strand_queue.sv
/*
 * Instruction queue for one strand, written by fetch and read by the select stage.
 * Valid/ready on both sides; the write side stalls while the queue is full.
 */

`timescale 1ns/1ns

`include "issue_params.svh"

module strand_queue
	#(parameter DEPTH = `QUEUE_DEPTH)
	(input clk,
	input reset,

	// Fetch side
	input in_valid,
	input issue_pkg::word_t in_pc,
	input issue_pkg::word_t in_instruction,
	input in_long_latency,
	output logic in_ready,

	// Select stage side
	output logic out_valid,
	output issue_pkg::word_t out_pc,
	output issue_pkg::word_t out_instruction,
	output logic out_long_latency,
	input out_ready);

	localparam PTR_WIDTH = DEPTH > 1 ? $clog2(DEPTH) : 1;
	localparam COUNT_WIDTH = $clog2(DEPTH + 1);

	issue_pkg::queue_entry_t entries[DEPTH];
	issue_pkg::queue_entry_t head;
	logic [PTR_WIDTH - 1:0] wr_ptr;
	logic [PTR_WIDTH - 1:0] rd_ptr;
	logic [COUNT_WIDTH - 1:0] count;
	logic [COUNT_WIDTH - 1:0] count_next;
	logic push;
	logic pop;

	// Transfers on both sides
	assign push = in_valid && in_ready;
	assign pop = out_ready && out_valid;
	assign count_next = count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);

	// Head of queue straight to the select stage
	assign head = entries[rd_ptr];
	assign out_valid = count != '0;
	assign out_pc = head.pc;
	assign out_instruction = head.instruction;
	assign out_long_latency = head.long_latency;

	// Storage, no reset needed
	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= '{pc: in_pc, instruction: in_instruction,
				long_latency: in_long_latency};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			// Held off during reset, opens the cycle after
			in_ready <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr == PTR_WIDTH'(DEPTH - 1) ? '0 : wr_ptr + 1'b1;

			if (pop)
				rd_ptr <= rd_ptr == PTR_WIDTH'(DEPTH - 1) ? '0 : rd_ptr + 1'b1;

			count <= count_next;

			// Registered full flag
			in_ready <= count_next != COUNT_WIDTH'(DEPTH);
		end
	end
endmodule

//--- hdl/issue_pkg.sv
/*
 * Types shared between the strand queues, select stage and execute pipelines.
 * Referenced by scoped name from each module.
 */

`include "issue_params.svh"

package issue_pkg;

	// Program counter and instruction word
	typedef logic [31:0] word_t;

	// Strand number
	typedef logic [`STRAND_INDEX_WIDTH - 1:0] strand_idx_t;

	// One bit per strand, strand 0 in bit 0
	typedef logic [`STRANDS - 1:0] strand_mask_t;

	// One queued instruction, 65 bits
	typedef struct packed
	{
		word_t pc;
		word_t instruction;
		logic long_latency;
	} queue_entry_t;

endpackage

//--- hdl/issue_params.svh
/*
 * Sizes and encodings shared by the issue side of the core.
 * Include wherever a strand count, depth or the NOP word is needed.
 */

`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Strand count and the width of a strand number
`define STRANDS 4
`define STRAND_INDEX_WIDTH 2

// Entries in each per-strand queue
`define QUEUE_DEPTH 4

// Register stages in the multi-cycle execute pipeline
`define LONG_STAGES 3

// Issued when no strand is ready
`define NOP 32'h00000000

`endif
